// ==== src.f ====
common/frontend_pkg.sv
ibuf/pre_decoder.sv
ibuf/fetch_compact.sv
ibuf/inst_buffer.sv
rtl/flush_ctrl.sv
rtl/operand_extract.sv
rtl/frontend_top.sv
dv/frontend_tb.sv

// ==== Makefile ====
TOP := frontend_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f $(wildcard common/*.sv rtl/*.sv ibuf/*.sv dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f src.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

lint:
	verilator --lint-only --timing --top-module frontend_top -f src.f

clean:
	rm -rf obj_dir

// ==== dv/frontend_tb.sv ====
// frontend random testbench
`timescale 1ns/100ps

module frontend_tb;

  localparam int FW = frontend_pkg::FETCH_WIDTH;
  localparam int DW = frontend_pkg::DECODE_WIDTH;
  localparam int STIM_CYCLES = 3000;
  // stimulus, reset and drain with margin
  localparam int MAX_CYCLES = 4000;

  logic clk;
  logic rst_n;
  logic fetch_valid_i;
  logic [FW-1:0] fetch_slot_valid_i;
  frontend_pkg::addr_t  [FW-1:0] fetch_pc_i;
  frontend_pkg::instr_t [FW-1:0] fetch_instr_i;
  logic fetch_ready_o;
  logic cmt_valid_i;
  logic cmt_excp_i;
  frontend_pkg::ecode_t cmt_ecode_i;
  logic cmt_br_redirect_i;
  frontend_pkg::addr_t cmt_br_target_i;
  logic cmt_ertn_i;
  logic cmt_refetch_i;
  logic cmt_idle_i;
  frontend_pkg::addr_t cmt_pc_i;
  frontend_pkg::addr_t eentry_i;
  frontend_pkg::addr_t era_i;
  frontend_pkg::addr_t tlbrentry_i;
  logic has_int_i;
  logic flush_o;
  frontend_pkg::addr_t redirect_target_o;
  logic fetch_next_o;
  logic dec_ready_i;
  logic [DW-1:0] dec_valid_o;
  frontend_pkg::addr_t  [DW-1:0] dec_pc_o;
  frontend_pkg::instr_t [DW-1:0] dec_instr_o;
  frontend_pkg::areg_t  [DW-1:0] dec_src0_o;
  frontend_pkg::areg_t  [DW-1:0] dec_src1_o;
  frontend_pkg::areg_t  [DW-1:0] dec_dest_o;

  // ====================
  // model state
  // ====================
  frontend_pkg::addr_t  q_pc[$];
  frontend_pkg::instr_t q_instr[$];
  frontend_pkg::addr_t  prev_pc[DW];
  frontend_pkg::instr_t prev_instr[DW];
  frontend_pkg::addr_t  pc_base = 32'h1c00_0000;
  logic [DW-1:0] prev_valid = '0;
  logic hold_prev = 1'b0;
  logic flush_prev = 1'b0;
  logic lock_m = 1'b0;
  // entries in the buffer and slots in the packet register
  int buf_m = 0;
  int pkt_m = 0;
  logic [31:0] rng = 32'd75463;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  frontend_top dut (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // one of the five classes, random register fields
  function automatic frontend_pkg::instr_t make_instr();
    logic [31:0] r;
    logic [31:0] f;
    r = next_rand();
    f = next_rand();
    case (r % 5)
      0: return {12'h001, f[19:0]};
      1: return {10'b0000001010, f[21:0]};
      2: return {6'b010110, f[25:0]};
      3: return {6'b010101, f[25:0]};
      default: return f;
    endcase
  endfunction

  // {src0, src1, dest} from the class table
  function automatic logic [14:0] expected_regs(input frontend_pkg::instr_t ins);
    frontend_pkg::areg_t rd;
    frontend_pkg::areg_t rj;
    frontend_pkg::areg_t rk;
    rd = ins[4:0];
    rj = ins[9:5];
    rk = ins[14:10];
    if (ins[31:20] == 12'h001) begin
      return {rj, rk, rd};
    end else if (ins[31:22] == 10'b0000001010) begin
      return {rj, 5'd0, rd};
    end else if (ins[31:26] == 6'b010110) begin
      return {rj, rd, 5'd0};
    end else if (ins[31:26] == 6'b010101) begin
      return {5'd0, 5'd0, 5'd1};
    end
    return 15'd0;
  endfunction

  function automatic frontend_pkg::addr_t expected_target();
    if (!cmt_valid_i) return 32'h1c00_0000;
    if (cmt_excp_i && cmt_ecode_i == 6'h3f) return tlbrentry_i;
    if (cmt_excp_i) return eentry_i;
    if (cmt_br_redirect_i) return cmt_br_target_i;
    if (cmt_ertn_i) return era_i;
    if (cmt_refetch_i || cmt_idle_i) return cmt_pc_i + 32'd4;
    return 32'h1c00_0000;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic drive_quiet();
    fetch_valid_i      = 1'b0;
    fetch_slot_valid_i = '0;
    fetch_pc_i         = '0;
    fetch_instr_i      = '0;
    dec_ready_i        = 1'b1;
    cmt_valid_i        = 1'b0;
    cmt_excp_i         = 1'b0;
    cmt_ecode_i        = '0;
    cmt_br_redirect_i  = 1'b0;
    cmt_br_target_i    = '0;
    cmt_ertn_i         = 1'b0;
    cmt_refetch_i      = 1'b0;
    cmt_idle_i         = 1'b0;
    cmt_pc_i           = '0;
    eentry_i           = '0;
    era_i              = '0;
    tlbrentry_i        = '0;
    has_int_i          = 1'b0;
  endtask

  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] e;
    r = next_rand();
    e = next_rand();
    fetch_valid_i      = (r[1:0] != 2'b00);
    fetch_slot_valid_i = r[5:2];
    dec_ready_i        = (r[8:6] > 3'd2);
    // commits are rare so the buffer gets to fill
    cmt_valid_i        = (r[13:9] == 5'd0);
    cmt_excp_i         = (r[15:14] == 2'd0);
    cmt_br_redirect_i  = (r[17:16] == 2'd0);
    cmt_ertn_i         = (r[19:18] == 2'd0);
    cmt_refetch_i      = (r[21:20] == 2'd0);
    cmt_idle_i         = (r[23:22] == 2'd0);
    has_int_i          = (r[28:24] == 5'd0);
    cmt_ecode_i        = r[29] ? 6'h3f : e[5:0];
    cmt_br_target_i    = next_rand();
    cmt_pc_i           = next_rand();
    eentry_i           = next_rand();
    era_i              = next_rand();
    tlbrentry_i        = next_rand();
    for (int i = 0; i < FW; i++) begin
      fetch_pc_i[i]    = pc_base + 32'(4 * i);
      fetch_instr_i[i] = make_instr();
    end
    pc_base = pc_base + 32'd16;
  endtask

  // checks the settled outputs, then steps the model past the next edge
  task automatic check_and_update();
    logic exp_flush;
    logic exp_ready;
    logic [14:0] regs;
    int pops;
    #10;
    checks++;
    exp_flush = cmt_valid_i & (cmt_excp_i | cmt_br_redirect_i | cmt_ertn_i
                               | cmt_refetch_i | cmt_idle_i);
    // room for a whole packet in the buffer
    exp_ready = (frontend_pkg::IBUF_DEPTH - buf_m >= FW);
    if (flush_o !== exp_flush) begin
      report_error($sformatf("flush_o %b, expected %b", flush_o, exp_flush));
    end
    if (redirect_target_o !== expected_target()) begin
      report_error($sformatf("redirect target %h, expected %h",
                             redirect_target_o, expected_target()));
    end
    if (fetch_ready_o !== exp_ready) begin
      report_error($sformatf("fetch_ready_o %b, expected %b with %0d entries",
                             fetch_ready_o, exp_ready, buf_m));
    end
    if (fetch_next_o !== (fetch_ready_o & ~lock_m)) begin
      report_error($sformatf("fetch_next_o %b with lock %b", fetch_next_o, lock_m));
    end
    if (flush_prev && dec_valid_o !== '0) begin
      report_error("decode valid right after a flush");
    end
    for (int k = 1; k < DW; k++) begin
      if (dec_valid_o[k] && !dec_valid_o[k-1]) begin
        report_error($sformatf("dec_valid_o %b not contiguous", dec_valid_o));
      end
    end
    for (int k = 0; k < DW; k++) begin
      if (dec_valid_o[k] !== (buf_m > k)) begin
        report_error($sformatf("dec_valid_o %b with %0d entries buffered",
                               dec_valid_o, buf_m));
      end
      if (hold_prev && prev_valid[k] && (!dec_valid_o[k] || dec_pc_o[k] !== prev_pc[k]
          || dec_instr_o[k] !== prev_instr[k])) begin
        report_error($sformatf("port %0d changed while decode stalled", k));
      end
      if (dec_valid_o[k]) begin
        if (k >= q_pc.size()) begin
          report_error($sformatf("port %0d valid with no entry expected", k));
        end else begin
          regs = expected_regs(q_instr[k]);
          if (dec_pc_o[k] !== q_pc[k] || dec_instr_o[k] !== q_instr[k]) begin
            report_error($sformatf("port %0d pc %h instr %h, expected pc %h instr %h", k,
                                   dec_pc_o[k], dec_instr_o[k], q_pc[k], q_instr[k]));
          end
          if ({dec_src0_o[k], dec_src1_o[k], dec_dest_o[k]} !== regs) begin
            report_error($sformatf("port %0d regs %h %h %h, expected %h", k, dec_src0_o[k],
                                   dec_src1_o[k], dec_dest_o[k], regs));
          end
        end
      end
    end
    if (exp_flush) begin
      q_pc.delete();
      q_instr.delete();
      buf_m = 0;
      pkt_m = 0;
    end else begin
      for (int k = 0; k < DW; k++) begin
        if (dec_ready_i && dec_valid_o[k] && q_pc.size() > 0) begin
          void'(q_pc.pop_front());
          void'(q_instr.pop_front());
        end
      end
      pops = 0;
      if (dec_ready_i) begin
        pops = (buf_m < DW) ? buf_m : DW;
      end
      if (exp_ready) begin
        // held packet moves into the buffer, the register takes the new one
        buf_m = buf_m - pops + pkt_m;
        pkt_m = 0;
        if (fetch_valid_i) begin
          for (int i = 0; i < FW; i++) begin
            if (fetch_slot_valid_i[i]) begin
              q_pc.push_back(fetch_pc_i[i]);
              q_instr.push_back(fetch_instr_i[i]);
              pkt_m++;
            end
          end
        end
      end else begin
        buf_m = buf_m - pops;
      end
    end
    if (cmt_valid_i && cmt_idle_i && !has_int_i) begin
      lock_m = 1'b1;
    end else if (has_int_i) begin
      lock_m = 1'b0;
    end
    hold_prev  = !dec_ready_i && !exp_flush;
    flush_prev = exp_flush;
    prev_valid = dec_valid_o;
    for (int k = 0; k < DW; k++) begin
      prev_pc[k]    = dec_pc_o[k];
      prev_instr[k] = dec_instr_o[k];
    end
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    rst_n = 1'b0;
    drive_quiet();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    #10;
    if (!fetch_ready_o || dec_valid_o !== '0 || fetch_next_o !== 1'b1) begin
      report_error("outputs not idle after reset");
    end
    for (int n = 0; n < STIM_CYCLES; n++) begin
      @(negedge clk);
      drive_random();
      check_and_update();
    end
    // drain whatever is still expected
    while (q_pc.size() != 0) begin
      @(negedge clk);
      drive_quiet();
      check_and_update();
    end
    repeat (2) begin
      @(negedge clk);
      drive_quiet();
      check_and_update();
    end
    if (dec_valid_o !== '0) begin
      report_error("entries left in the buffer after drain");
    end
    $display("frontend_tb: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== rtl/frontend_top.sv ====
// out-of-order core frontend
`timescale 1ns/100ps

module frontend_top (
  input  logic                                             clk,
  input  logic                                             rst_n,
  // fetch side
  input  logic                                             fetch_valid_i,
  input  logic [frontend_pkg::FETCH_WIDTH-1:0]             fetch_slot_valid_i,
  input  frontend_pkg::addr_t  [frontend_pkg::FETCH_WIDTH-1:0] fetch_pc_i,
  input  frontend_pkg::instr_t [frontend_pkg::FETCH_WIDTH-1:0] fetch_instr_i,
  output logic                                             fetch_ready_o,
  // commit entry
  input  logic                                             cmt_valid_i,
  input  logic                                             cmt_excp_i,
  input  frontend_pkg::ecode_t                             cmt_ecode_i,
  input  logic                                             cmt_br_redirect_i,
  input  frontend_pkg::addr_t                              cmt_br_target_i,
  input  logic                                             cmt_ertn_i,
  input  logic                                             cmt_refetch_i,
  input  logic                                             cmt_idle_i,
  input  frontend_pkg::addr_t                              cmt_pc_i,
  // csr side
  input  frontend_pkg::addr_t                              eentry_i,
  input  frontend_pkg::addr_t                              era_i,
  input  frontend_pkg::addr_t                              tlbrentry_i,
  input  logic                                             has_int_i,
  // redirect toward fetch
  output logic                                             flush_o,
  output frontend_pkg::addr_t                              redirect_target_o,
  output logic                                             fetch_next_o,
  // decode side
  input  logic                                             dec_ready_i,
  output logic [frontend_pkg::DECODE_WIDTH-1:0]            dec_valid_o,
  output frontend_pkg::addr_t  [frontend_pkg::DECODE_WIDTH-1:0] dec_pc_o,
  output frontend_pkg::instr_t [frontend_pkg::DECODE_WIDTH-1:0] dec_instr_o,
  output frontend_pkg::areg_t  [frontend_pkg::DECODE_WIDTH-1:0] dec_src0_o,
  output frontend_pkg::areg_t  [frontend_pkg::DECODE_WIDTH-1:0] dec_src1_o,
  output frontend_pkg::areg_t  [frontend_pkg::DECODE_WIDTH-1:0] dec_dest_o
);

  logic [frontend_pkg::FETCH_WIDTH-1:0]                       ibuf_wr_valid;
  frontend_pkg::ibuf_data_t [frontend_pkg::FETCH_WIDTH-1:0]   ibuf_wr_data;
  frontend_pkg::ibuf_data_t [frontend_pkg::DECODE_WIDTH-1:0]  ibuf_rd_data;

  // ====================
  // commit control
  // ====================
  flush_ctrl u_flush_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .cmt_valid_i       (cmt_valid_i),
    .cmt_excp_i        (cmt_excp_i),
    .cmt_ecode_i       (cmt_ecode_i),
    .cmt_br_redirect_i (cmt_br_redirect_i),
    .cmt_br_target_i   (cmt_br_target_i),
    .cmt_ertn_i        (cmt_ertn_i),
    .cmt_refetch_i     (cmt_refetch_i),
    .cmt_idle_i        (cmt_idle_i),
    .cmt_pc_i          (cmt_pc_i),
    .eentry_i          (eentry_i),
    .era_i             (era_i),
    .tlbrentry_i       (tlbrentry_i),
    .has_int_i         (has_int_i),
    .wr_ready_i        (fetch_ready_o),
    .flush_o           (flush_o),
    .redirect_target_o (redirect_target_o),
    .fetch_next_o      (fetch_next_o)
  );

  // ====================
  // fetch packet and buffer
  // ====================
  fetch_compact u_fetch_compact (
    .clk                (clk),
    .rst_n              (rst_n),
    .flush_i            (flush_o),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_slot_valid_i (fetch_slot_valid_i),
    .fetch_pc_i         (fetch_pc_i),
    .fetch_instr_i      (fetch_instr_i),
    .wr_ready_i         (fetch_ready_o),
    .wr_valid_o         (ibuf_wr_valid),
    .wr_data_o          (ibuf_wr_data)
  );

  // write ready doubles as the fetch ready level
  inst_buffer u_inst_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_o),
    .wr_valid_i (ibuf_wr_valid),
    .wr_data_i  (ibuf_wr_data),
    .wr_ready_o (fetch_ready_o),
    .rd_ready_i (dec_ready_i),
    .rd_valid_o (dec_valid_o),
    .rd_data_o  (ibuf_rd_data)
  );

  // ====================
  // decode operands
  // ====================
  operand_extract u_operand_extract (
    .rd_data_i   (ibuf_rd_data),
    .dec_pc_o    (dec_pc_o),
    .dec_instr_o (dec_instr_o),
    .dec_src0_o  (dec_src0_o),
    .dec_src1_o  (dec_src1_o),
    .dec_dest_o  (dec_dest_o)
  );

endmodule

// ==== rtl/operand_extract.sv ====
// decode operand register extraction
`timescale 1ns/100ps

module operand_extract (
  input  frontend_pkg::ibuf_data_t [frontend_pkg::DECODE_WIDTH-1:0] rd_data_i,
  output frontend_pkg::addr_t      [frontend_pkg::DECODE_WIDTH-1:0] dec_pc_o,
  output frontend_pkg::instr_t     [frontend_pkg::DECODE_WIDTH-1:0] dec_instr_o,
  output frontend_pkg::areg_t      [frontend_pkg::DECODE_WIDTH-1:0] dec_src0_o,
  output frontend_pkg::areg_t      [frontend_pkg::DECODE_WIDTH-1:0] dec_src1_o,
  output frontend_pkg::areg_t      [frontend_pkg::DECODE_WIDTH-1:0] dec_dest_o
);

  function automatic frontend_pkg::areg_t src_reg(input logic [1:0] sel,
                                                  input frontend_pkg::instr_t instr);
    case (frontend_pkg::src_sel_e'(sel))
      frontend_pkg::SRC_RD: src_reg = instr[4:0];
      frontend_pkg::SRC_RJ: src_reg = instr[9:5];
      frontend_pkg::SRC_RK: src_reg = instr[14:10];
      default:              src_reg = 5'd0;
    endcase
  endfunction

  function automatic frontend_pkg::areg_t dest_reg(input logic [1:0] sel,
                                                   input frontend_pkg::instr_t instr);
    case (frontend_pkg::dest_sel_e'(sel))
      frontend_pkg::DEST_RD: dest_reg = instr[4:0];
      // link register for bl
      frontend_pkg::DEST_RA: dest_reg = 5'd1;
      default:               dest_reg = 5'd0;
    endcase
  endfunction

  // word layout {pc, instr, src0, src1, dest}
  always_comb begin
    for (int k = 0; k < frontend_pkg::DECODE_WIDTH; k++) begin
      dec_pc_o[k]    = rd_data_i[k][69:38];
      dec_instr_o[k] = rd_data_i[k][37:6];
      dec_src0_o[k]  = src_reg(rd_data_i[k][5:4], rd_data_i[k][37:6]);
      dec_src1_o[k]  = src_reg(rd_data_i[k][3:2], rd_data_i[k][37:6]);
      dec_dest_o[k]  = dest_reg(rd_data_i[k][1:0], rd_data_i[k][37:6]);
    end
  end

endmodule

// ==== rtl/flush_ctrl.sv ====
// commit flush and redirect control
`timescale 1ns/100ps

module flush_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cmt_valid_i,
  input  logic                 cmt_excp_i,
  input  frontend_pkg::ecode_t cmt_ecode_i,
  input  logic                 cmt_br_redirect_i,
  input  frontend_pkg::addr_t  cmt_br_target_i,
  input  logic                 cmt_ertn_i,
  input  logic                 cmt_refetch_i,
  input  logic                 cmt_idle_i,
  input  frontend_pkg::addr_t  cmt_pc_i,
  input  frontend_pkg::addr_t  eentry_i,
  input  frontend_pkg::addr_t  era_i,
  input  frontend_pkg::addr_t  tlbrentry_i,
  input  logic                 has_int_i,
  input  logic                 wr_ready_i,
  output logic                 flush_o,
  output frontend_pkg::addr_t  redirect_target_o,
  output logic                 fetch_next_o
);

  logic excp_flush;
  logic tlbr_flush;
  logic redirect_flush;
  logic ertn_flush;
  logic idle_flush;
  logic refetch_flush;
  logic idle_lock;

  // ====================
  // flush causes
  // ====================
  always_comb begin
    excp_flush     = cmt_valid_i & cmt_excp_i;
    // tlb refill has its own entry
    tlbr_flush     = excp_flush & (cmt_ecode_i == frontend_pkg::ECODE_TLBR);
    redirect_flush = cmt_valid_i & cmt_br_redirect_i;
    ertn_flush     = cmt_valid_i & cmt_ertn_i;
    idle_flush     = cmt_valid_i & cmt_idle_i;
    // idle restarts at the next pc like a refetch
    refetch_flush  = cmt_valid_i & (cmt_refetch_i | cmt_idle_i);
    flush_o        = excp_flush | redirect_flush | ertn_flush | refetch_flush;
  end

  // redirect target by priority
  always_comb begin
    if (tlbr_flush) begin
      redirect_target_o = tlbrentry_i;
    end else if (excp_flush) begin
      redirect_target_o = eentry_i;
    end else if (redirect_flush) begin
      redirect_target_o = cmt_br_target_i;
    end else if (ertn_flush) begin
      redirect_target_o = era_i;
    end else if (refetch_flush) begin
      redirect_target_o = cmt_pc_i + 32'd4;
    end else begin
      redirect_target_o = frontend_pkg::RESET_PC;
    end
  end

  // ====================
  // idle lock
  // ====================
  // holds fetch until an interrupt is pending
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idle_lock <= 1'b0;
    end else if (idle_flush && !has_int_i) begin
      idle_lock <= 1'b1;
    end else if (has_int_i) begin
      idle_lock <= 1'b0;
    end
  end

  assign fetch_next_o = wr_ready_i & ~idle_lock;

  a_flush_needs_commit : assert property (
    @(posedge clk) disable iff (!rst_n) flush_o |-> cmt_valid_i
  );

endmodule

// ==== ibuf/inst_buffer.sv ====
// multi-port instruction buffer
`timescale 1ns/100ps

module inst_buffer (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      flush_i,
  input  logic [frontend_pkg::FETCH_WIDTH-1:0]                      wr_valid_i,
  input  frontend_pkg::ibuf_data_t [frontend_pkg::FETCH_WIDTH-1:0]  wr_data_i,
  output logic                                                      wr_ready_o,
  input  logic                                                      rd_ready_i,
  output logic [frontend_pkg::DECODE_WIDTH-1:0]                     rd_valid_o,
  output frontend_pkg::ibuf_data_t [frontend_pkg::DECODE_WIDTH-1:0] rd_data_o
);

  frontend_pkg::ibuf_data_t mem [frontend_pkg::IBUF_DEPTH];

  frontend_pkg::ptr_t head;
  frontend_pkg::ptr_t tail;
  frontend_pkg::cnt_t count;
  frontend_pkg::cnt_t wr_num;
  frontend_pkg::cnt_t rd_num;

  logic wr_fire;
  logic rd_fire;

  // ====================
  // status
  // ====================
  // room for a full packet, from the registered count
  assign wr_ready_o = (count <= frontend_pkg::cnt_t'(frontend_pkg::IBUF_DEPTH
                                                     - frontend_pkg::FETCH_WIDTH));
  assign wr_fire    = wr_ready_o & ~flush_i;
  assign rd_fire    = rd_ready_i & ~flush_i;

  // show-ahead read of the oldest entries
  always_comb begin
    for (int k = 0; k < frontend_pkg::DECODE_WIDTH; k++) begin
      rd_valid_o[k] = (count > frontend_pkg::cnt_t'(k));
      rd_data_o[k]  = mem[head + frontend_pkg::ptr_t'(k)];
    end
  end

  // slot counts, both sides are contiguous from slot 0
  always_comb begin
    wr_num = '0;
    rd_num = '0;
    for (int k = 0; k < frontend_pkg::FETCH_WIDTH; k++) begin
      if (wr_fire && wr_valid_i[k]) begin
        wr_num = wr_num + frontend_pkg::cnt_t'(1);
      end
    end
    for (int k = 0; k < frontend_pkg::DECODE_WIDTH; k++) begin
      if (rd_fire && rd_valid_o[k]) begin
        rd_num = rd_num + frontend_pkg::cnt_t'(1);
      end
    end
  end

  // ====================
  // storage and pointers
  // ====================
  always_ff @(posedge clk) begin
    for (int k = 0; k < frontend_pkg::FETCH_WIDTH; k++) begin
      if (wr_fire && wr_valid_i[k]) begin
        mem[tail + frontend_pkg::ptr_t'(k)] <= wr_data_i[k];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush_i) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      // depth is a power of two, pointers wrap on their own
      head  <= head + frontend_pkg::ptr_t'(rd_num);
      tail  <= tail + frontend_pkg::ptr_t'(wr_num);
      count <= count + wr_num - rd_num;
    end
  end

  a_count_bound : assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= frontend_pkg::cnt_t'(frontend_pkg::IBUF_DEPTH)
  );

  // valid ports form a run starting at port 0
  a_rd_contig : assert property (
    @(posedge clk) disable iff (!rst_n)
    (rd_valid_o & (rd_valid_o + 1'b1)) == '0
  );

endmodule

// ==== ibuf/fetch_compact.sv ====
// fetch packet register and slot compaction
`timescale 1ns/100ps

module fetch_compact (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic                                                     flush_i,
  input  logic                                                     fetch_valid_i,
  input  logic [frontend_pkg::FETCH_WIDTH-1:0]                     fetch_slot_valid_i,
  input  frontend_pkg::addr_t  [frontend_pkg::FETCH_WIDTH-1:0]     fetch_pc_i,
  input  frontend_pkg::instr_t [frontend_pkg::FETCH_WIDTH-1:0]     fetch_instr_i,
  input  logic                                                     wr_ready_i,
  output logic [frontend_pkg::FETCH_WIDTH-1:0]                     wr_valid_o,
  output frontend_pkg::ibuf_data_t [frontend_pkg::FETCH_WIDTH-1:0] wr_data_o
);

  logic [frontend_pkg::FETCH_WIDTH-1:0]                 pkt_valid;
  frontend_pkg::addr_t  [frontend_pkg::FETCH_WIDTH-1:0] pkt_pc;
  frontend_pkg::instr_t [frontend_pkg::FETCH_WIDTH-1:0] pkt_instr;

  frontend_pkg::src_sel_e  src0_sel [frontend_pkg::FETCH_WIDTH];
  frontend_pkg::src_sel_e  src1_sel [frontend_pkg::FETCH_WIDTH];
  frontend_pkg::dest_sel_e dest_sel [frontend_pkg::FETCH_WIDTH];

  // ====================
  // packet register
  // ====================
  // reloads only while the buffer can take the held packet
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pkt_valid <= '0;
    end else if (flush_i) begin
      pkt_valid <= '0;
    end else if (wr_ready_i) begin
      pkt_valid <= fetch_valid_i ? fetch_slot_valid_i : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ready_i) begin
      pkt_pc    <= fetch_pc_i;
      pkt_instr <= fetch_instr_i;
    end
  end

  // ====================
  // pre-decode per slot
  // ====================
  for (genvar i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin : gen_pre_dec
    pre_decoder u_pre_decoder (
      .instr_i    (pkt_instr[i]),
      .src0_sel_o (src0_sel[i]),
      .src1_sel_o (src1_sel[i]),
      .dest_sel_o (dest_sel[i])
    );
  end

  // squeeze out empty slots, keep slot order
  always_comb begin
    int unsigned idx;
    idx        = 0;
    wr_valid_o = '0;
    wr_data_o  = '0;
    for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
      if (pkt_valid[i]) begin
        wr_valid_o[idx] = 1'b1;
        wr_data_o[idx]  = {pkt_pc[i], pkt_instr[i], src0_sel[i], src1_sel[i], dest_sel[i]};
        idx             = idx + 1;
      end
    end
  end

endmodule

// ==== ibuf/pre_decoder.sv ====
// instruction class pre-decoder
`timescale 1ns/100ps

module pre_decoder (
  input  frontend_pkg::instr_t    instr_i,
  output frontend_pkg::src_sel_e  src0_sel_o,
  output frontend_pkg::src_sel_e  src1_sel_o,
  output frontend_pkg::dest_sel_e dest_sel_o
);

  logic is_3r;
  logic is_addi;
  logic is_beq;
  logic is_bl;

  // ====================
  // class match
  // ====================
  always_comb begin
    is_3r   = (instr_i[31:20] == 12'h001);
    is_addi = (instr_i[31:22] == 10'b0000001010);
    is_beq  = (instr_i[31:26] == 6'b010110);
    is_bl   = (instr_i[31:26] == 6'b010101);
  end

  // unknown encodings touch no registers
  always_comb begin
    src0_sel_o = frontend_pkg::SRC_R0;
    src1_sel_o = frontend_pkg::SRC_R0;
    dest_sel_o = frontend_pkg::DEST_R0;
    if (is_3r) begin
      src0_sel_o = frontend_pkg::SRC_RJ;
      src1_sel_o = frontend_pkg::SRC_RK;
      dest_sel_o = frontend_pkg::DEST_RD;
    end else if (is_addi) begin
      src0_sel_o = frontend_pkg::SRC_RJ;
      dest_sel_o = frontend_pkg::DEST_RD;
    end else if (is_beq) begin
      // compares rj with rd, no write
      src0_sel_o = frontend_pkg::SRC_RJ;
      src1_sel_o = frontend_pkg::SRC_RD;
    end else if (is_bl) begin
      dest_sel_o = frontend_pkg::DEST_RA;
    end
  end

endmodule

// ==== common/frontend_pkg.sv ====
// frontend shared definitions
package frontend_pkg;

  // ====================
  // basic vector types
  // ====================
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  areg_t;
  typedef logic [5:0]  ecode_t;

  // ====================
  // sizes
  // ====================
  // slots per fetch packet
  localparam int FETCH_WIDTH = 4;
  // read ports toward decode
  localparam int DECODE_WIDTH = 2;
  localparam int IBUF_DEPTH = 16;

  localparam int PTR_W = $clog2(IBUF_DEPTH);
  // count must reach IBUF_DEPTH itself
  localparam int CNT_W = $clog2(IBUF_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  // ====================
  // constants
  // ====================
  localparam addr_t  RESET_PC   = 32'h1c00_0000;
  localparam ecode_t ECODE_TLBR = 6'h3f;

  // ====================
  // operand selectors
  // ====================
  typedef enum logic [1:0] {
    SRC_R0 = 2'd0,
    SRC_RD = 2'd1,
    SRC_RJ = 2'd2,
    SRC_RK = 2'd3
  } src_sel_e;

  typedef enum logic [1:0] {
    DEST_R0 = 2'd0,
    DEST_RD = 2'd1,
    DEST_RA = 2'd2
  } dest_sel_e;

  // buffer word, msb first: pc, instr, src0, src1, dest
  localparam int IBUF_DATA_W = $bits(addr_t) + $bits(instr_t)
                             + 2 * $bits(src_sel_e) + $bits(dest_sel_e);

  typedef logic [IBUF_DATA_W-1:0] ibuf_data_t;

endpackage
